/* design/regNumPkg.sv */
package regNumPkg;

	localparam int gprCount = 32;
	localparam int gprIdxWidth = $clog2(gprCount);	// index into the stored file
	localparam int regIdWidth = 6;

	// bit of SR that selects the live register bank
	localparam int srBankBit = 29;

	// operand port identifiers with the general registers at 0..31
	typedef enum logic [regIdWidth-1:0] {
		R0 = 6'h00,		// aliases DLR
		R1 = 6'h01,		// aliases DHR
		R15 = 6'h0F,	// aliases SP
		idPc = 6'h20,
		idImm = 6'h3E,
		idZero = 6'h3F
	} gprId_t;

	// control register identifiers for the Cm and Co ports
	typedef enum logic [regIdWidth-1:0] {
		idCtrlPc = 6'h20,
		idLr = 6'h21,
		idSr = 6'h22,
		idVbr = 6'h23,
		idSpc = 6'h24,
		idSsp = 6'h25,
		idGbr = 6'h26,
		idTbr = 6'h27,
		idDlr = 6'h28,
		idDhr = 6'h29,
		idSlr = 6'h2A,
		idSsr = 6'h2B,
		idSgb = 6'h2C,
		idStb = 6'h2D
	} ctrlId_t;

endpackage

/* design/regDataPkg.sv */
package regDataPkg;

	localparam int wordWidth = 64;
	localparam int immWidth = 33;	// sign bit at the top

	typedef logic [wordWidth-1:0] word_t;

	// one write port for Ro or Co
	typedef struct packed {
		logic [regNumPkg::regIdWidth-1:0] id;
		word_t value;
	} writePort_t;

	// values the execute stage wants the registers to take next
	typedef struct packed {
		word_t sp;
		word_t pc;
		word_t pr;
		word_t sr;
		word_t dlr;
		word_t dhr;
		word_t gbr;
		word_t tbr;
	} pipeNext_t;

	// live control registers as seen by the pipeline
	typedef struct packed {
		word_t sp;
		word_t pc;
		word_t pr;
		word_t sr;
		word_t vbr;
		word_t dlr;
		word_t dhr;
		word_t gbr;
		word_t tbr;
	} ctrlView_t;

endpackage

/* design/gprFile.sv */
module gprFile (
	input logic clock,
	input logic reset,
	input regDataPkg::writePort_t gprWrite,
	input logic hold,
	output regDataPkg::word_t gprValues [regNumPkg::gprCount]
);

	logic writeEnable;

	// no writes while the pipeline is stalled or being reset
	assign writeEnable = !reset && !hold;

	for (genvar i = 0; i < regNumPkg::gprCount; i++)
	begin : slot
		localparam logic [regNumPkg::regIdWidth-1:0] slotId = i;

		if (slotId == regNumPkg::R0 || slotId == regNumPkg::R1 || slotId == regNumPkg::R15)
		begin : pipeSlot
			// these live in the control file
			assign gprValues[i] = '0;
		end
		else
		begin : plainSlot
			regDataPkg::word_t value;

			always_ff @(posedge clock)
			begin
				if (writeEnable && gprWrite.id == slotId)
					value <= gprWrite.value;	// ids above 31 never match
			end

			assign gprValues[i] = value;
		end
	end

endmodule

/* design/operandRead.sv */
module operandRead (
	input regNumPkg::gprId_t idRm,
	input regNumPkg::gprId_t idRn,
	input regNumPkg::gprId_t idRi,
	input regDataPkg::word_t gprValues [regNumPkg::gprCount],
	input regDataPkg::writePort_t gprWrite,
	input regDataPkg::pipeNext_t pipeNext,
	input logic [regDataPkg::immWidth-1:0] imm,
	input regDataPkg::word_t nextPc,
	output regDataPkg::word_t valRm,
	output regDataPkg::word_t valRn,
	output regDataPkg::word_t valRi
);

	regDataPkg::word_t immExt;

	// shared by all three ports
	assign immExt = {
		{(regDataPkg::wordWidth - regDataPkg::immWidth){imm[regDataPkg::immWidth-1]}},
		imm
	};

	// one read port with forwarding
	function automatic regDataPkg::word_t pickOperand(input regNumPkg::gprId_t id);
		logic [regNumPkg::regIdWidth-1:0] raw;
		regDataPkg::word_t value;

		raw = id;
		case (id)
			regNumPkg::R0: value = pipeNext.dlr;
			regNumPkg::R1: value = pipeNext.dhr;
			regNumPkg::R15: value = pipeNext.sp;
			regNumPkg::idPc: value = nextPc;
			regNumPkg::idImm: value = immExt;
			regNumPkg::idZero: value = '0;
			default:
			begin
				if (raw < regNumPkg::gprCount)
					value = gprValues[raw[regNumPkg::gprIdxWidth-1:0]];
				else
					value = '0;	// unnamed special
			end
		endcase

		// a same-cycle write to this id wins for any id
		if (raw == gprWrite.id)
			value = gprWrite.value;
		return value;
	endfunction

	always_comb
	begin
		valRm = pickOperand(idRm);
		valRn = pickOperand(idRn);
		valRi = pickOperand(idRi);
	end

endmodule

/* design/controlRegs.sv */
module controlRegs (
	input logic clock,
	input logic reset,
	input regDataPkg::writePort_t gprWrite,
	input regDataPkg::writePort_t ctrlWrite,
	input regDataPkg::pipeNext_t pipeNext,
	input regNumPkg::ctrlId_t idCm,
	input regDataPkg::word_t nextPc,
	input logic hold,
	output regDataPkg::word_t valCm,
	output regDataPkg::ctrlView_t ctrl
);

	// shadow bank
	regDataPkg::word_t shadowPc;
	regDataPkg::word_t shadowPr;
	regDataPkg::word_t shadowSr;
	regDataPkg::word_t shadowSp;
	regDataPkg::word_t shadowGb;
	regDataPkg::word_t shadowTb;

	logic bankBit;	// last seen SR.RB
	logic newBank;
	logic swap;

	assign newBank = pipeNext.sr[regNumPkg::srBankBit];
	assign swap = newBank != bankBit;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			ctrl <= '0;
			shadowPc <= '0;
			shadowPr <= '0;
			shadowSr <= '0;
			shadowSp <= '0;
			shadowGb <= '0;
			shadowTb <= '0;
			bankBit <= 1'b0;
		end
		else
		begin
			bankBit <= newBank;	// tracks SR even while held

			if (swap)
			begin
				ctrl.pr <= shadowPr;
				ctrl.gbr <= shadowGb;
				ctrl.tbr <= shadowTb;
				shadowPr <= pipeNext.pr;
				shadowGb <= pipeNext.gbr;
				shadowTb <= pipeNext.tbr;
				ctrl.sp <= shadowSp;
				shadowSp <= ctrl.sp;

				if (newBank)
				begin
					// entering the interrupt bank
					shadowPc <= ctrl.pc;
					ctrl.pc <= pipeNext.pc;
					shadowSr <= ctrl.sr;
					ctrl.sr <= pipeNext.sr;
				end
				else
				begin
					ctrl.pc <= shadowPc;
					shadowPc <= ctrl.pc;
					ctrl.sr <= shadowSr;
					shadowSr <= pipeNext.sr;
				end
			end
			else if (!hold)
			begin
				// R0, R1 and R15 from the Ro port
				ctrl.dlr <= (gprWrite.id == regNumPkg::R0) ? gprWrite.value : pipeNext.dlr;
				ctrl.dhr <= (gprWrite.id == regNumPkg::R1) ? gprWrite.value : pipeNext.dhr;
				ctrl.sp <= (gprWrite.id == regNumPkg::R15) ? gprWrite.value : pipeNext.sp;

				ctrl.pc <= (ctrlWrite.id == regNumPkg::idCtrlPc) ? ctrlWrite.value : pipeNext.pc;
				ctrl.pr <= (ctrlWrite.id == regNumPkg::idLr) ? ctrlWrite.value : pipeNext.pr;
				ctrl.sr <= (ctrlWrite.id == regNumPkg::idSr) ? ctrlWrite.value : pipeNext.sr;

				// these only move on an explicit Co write
				if (ctrlWrite.id == regNumPkg::idVbr)
					ctrl.vbr <= ctrlWrite.value;
				if (ctrlWrite.id == regNumPkg::idGbr)
					ctrl.gbr <= ctrlWrite.value;
				if (ctrlWrite.id == regNumPkg::idTbr)
					ctrl.tbr <= ctrlWrite.value;
				if (ctrlWrite.id == regNumPkg::idSpc)
					shadowPc <= ctrlWrite.value;
				if (ctrlWrite.id == regNumPkg::idSlr)
					shadowPr <= ctrlWrite.value;
				if (ctrlWrite.id == regNumPkg::idSsr)
					shadowSr <= ctrlWrite.value;
				if (ctrlWrite.id == regNumPkg::idSsp)
					shadowSp <= ctrlWrite.value;
				if (ctrlWrite.id == regNumPkg::idSgb)
					shadowGb <= ctrlWrite.value;
				if (ctrlWrite.id == regNumPkg::idStb)
					shadowTb <= ctrlWrite.value;
			end
		end
	end

	// Cm read port with PC, LR, DLR and DHR taken from the pipe
	always_comb
	begin
		case (idCm)
			regNumPkg::idCtrlPc: valCm = nextPc;
			regNumPkg::idLr: valCm = pipeNext.pr;
			regNumPkg::idSr: valCm = ctrl.sr;
			regNumPkg::idVbr: valCm = ctrl.vbr;
			regNumPkg::idDlr: valCm = pipeNext.dlr;
			regNumPkg::idDhr: valCm = pipeNext.dhr;
			regNumPkg::idGbr: valCm = ctrl.gbr;
			regNumPkg::idTbr: valCm = ctrl.tbr;
			regNumPkg::idSpc: valCm = shadowPc;
			regNumPkg::idSlr: valCm = shadowPr;
			regNumPkg::idSsr: valCm = shadowSr;
			regNumPkg::idSsp: valCm = shadowSp;
			regNumPkg::idSgb: valCm = shadowGb;
			regNumPkg::idStb: valCm = shadowTb;
			default: valCm = '0;
		endcase

		if (idCm == ctrlWrite.id)
			valCm = ctrlWrite.value;	// Co forwarding
	end

endmodule

/* design/regBank.sv */
module regBank (
	input logic clock,
	input logic reset,
	input regNumPkg::gprId_t idRm,
	input regNumPkg::gprId_t idRn,
	input regNumPkg::gprId_t idRi,
	input regNumPkg::ctrlId_t idCm,
	input regDataPkg::writePort_t gprWrite,	// Ro
	input regDataPkg::writePort_t ctrlWrite,	// Co
	input regDataPkg::pipeNext_t pipeNext,
	input logic [regDataPkg::immWidth-1:0] imm,
	input regDataPkg::word_t nextPc,
	input logic hold,
	output regDataPkg::word_t valRm,
	output regDataPkg::word_t valRn,
	output regDataPkg::word_t valRi,
	output regDataPkg::word_t valCm,
	output regDataPkg::ctrlView_t ctrl
);

	regDataPkg::word_t gprValues [regNumPkg::gprCount];

	gprFile gprStore (
		.clock(clock),
		.reset(reset),
		.gprWrite(gprWrite),
		.hold(hold),
		.gprValues(gprValues)
	);

	operandRead operands (
		.idRm(idRm),
		.idRn(idRn),
		.idRi(idRi),
		.gprValues(gprValues),
		.gprWrite(gprWrite),
		.pipeNext(pipeNext),
		.imm(imm),
		.nextPc(nextPc),
		.valRm(valRm),
		.valRn(valRn),
		.valRi(valRi)
	);

	// also owns R0, R1 and R15 via DLR, DHR and SP
	controlRegs control (
		.clock(clock),
		.reset(reset),
		.gprWrite(gprWrite),
		.ctrlWrite(ctrlWrite),
		.pipeNext(pipeNext),
		.idCm(idCm),
		.nextPc(nextPc),
		.hold(hold),
		.valCm(valCm),
		.ctrl(ctrl)
	);

endmodule

/* dv/regBankTb.sv */
module regBankTb;

	localparam int clockPeriod = 40;
	localparam int resetCycles = 3;
	localparam int fillCycles = 29;	// plain registers 2..31 without 15
	localparam int randomCycles = 436;
	localparam int swapCycles = 32;
	// four times the length of all phases
	localparam int watchdogCycles = 4 * (resetCycles + fillCycles + randomCycles + swapCycles);

	typedef struct packed {
		regDataPkg::word_t rm;
		regDataPkg::word_t rn;
		regDataPkg::word_t ri;
		regDataPkg::word_t cm;
		regDataPkg::ctrlView_t ctrl;
	} expected_t;

	logic clock = 1'b0;
	logic reset;
	regNumPkg::gprId_t idRm;
	regNumPkg::gprId_t idRn;
	regNumPkg::gprId_t idRi;
	regNumPkg::ctrlId_t idCm;
	regDataPkg::writePort_t gprWrite;
	regDataPkg::writePort_t ctrlWrite;
	regDataPkg::pipeNext_t pipeNext;
	logic [regDataPkg::immWidth-1:0] imm;
	regDataPkg::word_t nextPc;
	logic hold;
	regDataPkg::word_t valRm;
	regDataPkg::word_t valRn;
	regDataPkg::word_t valRi;
	regDataPkg::word_t valCm;
	regDataPkg::ctrlView_t ctrl;

	// reference copy of the register state
	regDataPkg::word_t gprModel [regNumPkg::gprCount];
	regDataPkg::ctrlView_t ctrlModel;
	regDataPkg::word_t spcModel;
	regDataPkg::word_t sprModel;
	regDataPkg::word_t ssrModel;
	regDataPkg::word_t sspModel;
	regDataPkg::word_t sgbModel;
	regDataPkg::word_t stbModel;
	logic bankModel;

	logic [31:0] lfsr = 32'h50622dcb;
	logic bank;

	regBank dut_i (
		.clock(clock),
		.reset(reset),
		.idRm(idRm),
		.idRn(idRn),
		.idRi(idRi),
		.idCm(idCm),
		.gprWrite(gprWrite),
		.ctrlWrite(ctrlWrite),
		.pipeNext(pipeNext),
		.imm(imm),
		.nextPc(nextPc),
		.hold(hold),
		.valRm(valRm),
		.valRn(valRn),
		.valRi(valRi),
		.valCm(valCm),
		.ctrl(ctrl)
	);

	always #(clockPeriod / 2) clock = !clock;

	// x^32 + x^22 + x^2 + x + 1 stepped once per bit
	function automatic logic [63:0] randomBits(input int count);
		logic [63:0] bits;
		logic feedback;

		bits = '0;
		for (int i = 0; i < count; i++)
		begin
			feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], feedback};
			bits = {bits[62:0], feedback};
		end
		return bits;
	endfunction

	// biased toward the stored registers
	function automatic regNumPkg::gprId_t randomOperandId();
		logic [2:0] kind;

		kind = 3'(randomBits(3));
		case (kind)
			3'd4: return regNumPkg::idPc;
			3'd5: return regNumPkg::idImm;
			3'd6: return regNumPkg::idZero;
			3'd7: return regNumPkg::gprId_t'(6'(randomBits(6)));
			default: return regNumPkg::gprId_t'(6'(randomBits(5)));
		endcase
	endfunction

	function automatic logic [5:0] randomCtrlId();
		if (randomBits(2) == 0)
			return 6'(randomBits(6));
		return {2'b10, 4'(randomBits(4))};	// 0x20..0x2F with two unnamed
	endfunction

	function automatic regDataPkg::word_t predictOperand(input logic [5:0] id);
		regDataPkg::word_t value;

		if (id == regNumPkg::R0)
			value = pipeNext.dlr;
		else if (id == regNumPkg::R1)
			value = pipeNext.dhr;
		else if (id == regNumPkg::R15)
			value = pipeNext.sp;
		else if (id == regNumPkg::idPc)
			value = nextPc;
		else if (id == regNumPkg::idImm)
			value = {{31{imm[32]}}, imm};
		else if (id < 32)
			value = gprModel[id[4:0]];
		else
			value = '0;	// idZero and unnamed ones
		if (id == gprWrite.id)
			value = gprWrite.value;
		return value;
	endfunction

	function automatic regDataPkg::word_t predictCm(input logic [5:0] id);
		regDataPkg::word_t value;

		case (id)
			6'h20: value = nextPc;
			6'h21: value = pipeNext.pr;
			6'h22: value = ctrlModel.sr;
			6'h23: value = ctrlModel.vbr;
			6'h24: value = spcModel;
			6'h25: value = sspModel;
			6'h26: value = ctrlModel.gbr;
			6'h27: value = ctrlModel.tbr;
			6'h28: value = pipeNext.dlr;
			6'h29: value = pipeNext.dhr;
			6'h2A: value = sprModel;
			6'h2B: value = ssrModel;
			6'h2C: value = sgbModel;
			6'h2D: value = stbModel;
			default: value = '0;
		endcase
		if (id == ctrlWrite.id)
			value = ctrlWrite.value;
		return value;
	endfunction

	function automatic expected_t predictOutputs();
		expected_t result;

		result.rm = predictOperand(idRm);
		result.rn = predictOperand(idRn);
		result.ri = predictOperand(idRi);
		result.cm = predictCm(idCm);
		result.ctrl = ctrlModel;
		return result;
	endfunction

	task automatic resetModel();
		ctrlModel = '0;
		spcModel = '0;
		sprModel = '0;
		ssrModel = '0;
		sspModel = '0;
		sgbModel = '0;
		stbModel = '0;
		bankModel = 1'b0;
	endtask

	// state after the coming rising edge
	task automatic advanceModel();
		regDataPkg::ctrlView_t old;
		logic newBank;

		old = ctrlModel;
		newBank = pipeNext.sr[regNumPkg::srBankBit];
		if (!hold && gprWrite.id < 32 && gprWrite.id != regNumPkg::R0
				&& gprWrite.id != regNumPkg::R1 && gprWrite.id != regNumPkg::R15)
			gprModel[gprWrite.id[4:0]] = gprWrite.value;

		if (newBank != bankModel)
		begin
			ctrlModel.pr = sprModel;
			ctrlModel.gbr = sgbModel;
			ctrlModel.tbr = stbModel;
			sprModel = pipeNext.pr;
			sgbModel = pipeNext.gbr;
			stbModel = pipeNext.tbr;
			ctrlModel.sp = sspModel;
			sspModel = old.sp;
			if (newBank)
			begin
				spcModel = old.pc;
				ctrlModel.pc = pipeNext.pc;
				ssrModel = old.sr;
				ctrlModel.sr = pipeNext.sr;
			end
			else
			begin
				ctrlModel.pc = spcModel;	// leaving
				spcModel = old.pc;
				ctrlModel.sr = ssrModel;
				ssrModel = pipeNext.sr;
			end
		end
		else if (!hold)
		begin
			ctrlModel.dlr = (gprWrite.id == 6'h00) ? gprWrite.value : pipeNext.dlr;
			ctrlModel.dhr = (gprWrite.id == 6'h01) ? gprWrite.value : pipeNext.dhr;
			ctrlModel.sp = (gprWrite.id == 6'h0F) ? gprWrite.value : pipeNext.sp;
			ctrlModel.pc = (ctrlWrite.id == 6'h20) ? ctrlWrite.value : pipeNext.pc;
			ctrlModel.pr = (ctrlWrite.id == 6'h21) ? ctrlWrite.value : pipeNext.pr;
			ctrlModel.sr = (ctrlWrite.id == 6'h22) ? ctrlWrite.value : pipeNext.sr;
			case (ctrlWrite.id)
				6'h23: ctrlModel.vbr = ctrlWrite.value;
				6'h24: spcModel = ctrlWrite.value;
				6'h25: sspModel = ctrlWrite.value;
				6'h26: ctrlModel.gbr = ctrlWrite.value;
				6'h27: ctrlModel.tbr = ctrlWrite.value;
				6'h2A: sprModel = ctrlWrite.value;
				6'h2B: ssrModel = ctrlWrite.value;
				6'h2C: sgbModel = ctrlWrite.value;
				6'h2D: stbModel = ctrlWrite.value;
				default: ;
			endcase
		end
		bankModel = newBank;
	endtask

	task automatic checkWord(input string name, input regDataPkg::word_t actual,
			input regDataPkg::word_t expected);
		assert (actual === expected)
		else
		begin
			$display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
			$display("Something failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// outputs are settled half a cycle after the drive
	always @(negedge clock)
	begin
		expected_t expected;

		if (reset)
			resetModel();
		else
		begin
			expected = predictOutputs();
			checkWord("valRm", valRm, expected.rm);
			checkWord("valRn", valRn, expected.rn);
			checkWord("valRi", valRi, expected.ri);
			checkWord("valCm", valCm, expected.cm);
			checkWord("ctrl.sp", ctrl.sp, expected.ctrl.sp);
			checkWord("ctrl.pc", ctrl.pc, expected.ctrl.pc);
			checkWord("ctrl.pr", ctrl.pr, expected.ctrl.pr);
			checkWord("ctrl.sr", ctrl.sr, expected.ctrl.sr);
			checkWord("ctrl.vbr", ctrl.vbr, expected.ctrl.vbr);
			checkWord("ctrl.dlr", ctrl.dlr, expected.ctrl.dlr);
			checkWord("ctrl.dhr", ctrl.dhr, expected.ctrl.dhr);
			checkWord("ctrl.gbr", ctrl.gbr, expected.ctrl.gbr);
			checkWord("ctrl.tbr", ctrl.tbr, expected.ctrl.tbr);
			advanceModel();
		end
	end

	task automatic driveRandom(input logic bankValue, input logic holdValue);
		regDataPkg::pipeNext_t next;
		regDataPkg::writePort_t gw;
		regDataPkg::writePort_t cw;

		next.sp = randomBits(64);
		next.pc = randomBits(64);
		next.pr = randomBits(64);
		next.sr = randomBits(64);
		next.dlr = randomBits(64);
		next.dhr = randomBits(64);
		next.gbr = randomBits(64);
		next.tbr = randomBits(64);
		next.sr[regNumPkg::srBankBit] = bankValue;
		gw.id = (randomBits(2) == 0) ? 6'(randomBits(6)) : 6'(randomBits(5));
		gw.value = randomBits(64);
		cw.id = randomCtrlId();
		cw.value = randomBits(64);

		pipeNext <= next;
		gprWrite <= gw;
		ctrlWrite <= cw;
		imm <= 33'(randomBits(33));
		nextPc <= randomBits(64);
		hold <= holdValue;
		idRn <= randomOperandId();
		idRi <= randomOperandId();
		// same-cycle hits for the forwarding paths
		idRm <= (randomBits(2) == 0) ? regNumPkg::gprId_t'(gw.id) : randomOperandId();
		idCm <= (randomBits(2) == 0) ? regNumPkg::ctrlId_t'(cw.id)
				: regNumPkg::ctrlId_t'(randomCtrlId());
	endtask

	initial
	begin
		bank = 1'b0;
		reset <= 1'b1;
		idRm <= regNumPkg::idZero;
		idRn <= regNumPkg::idZero;
		idRi <= regNumPkg::idZero;
		idCm <= regNumPkg::ctrlId_t'(6'h3F);
		gprWrite <= '{id: 6'h3F, value: '0};
		ctrlWrite <= '{id: 6'h3F, value: '0};
		pipeNext <= '0;
		imm <= '0;
		nextPc <= '0;
		hold <= 1'b0;
		repeat (resetCycles) @(posedge clock);
		reset <= 1'b0;

		// fill every plain register while all ports read it through forwarding
		for (int id = 2; id < regNumPkg::gprCount; id++)
		begin
			if (id != 15)
			begin
				@(posedge clock);
				driveRandom(bank, 1'b0);
				gprWrite.id <= 6'(id);
				idRm <= regNumPkg::gprId_t'(6'(id));
				idRn <= regNumPkg::gprId_t'(6'(id));
				idRi <= regNumPkg::gprId_t'(6'(id));
			end
		end

		for (int n = 0; n < randomCycles; n++)
		begin
			@(posedge clock);
			if (randomBits(3) == 0)
				bank = !bank;
			driveRandom(bank, randomBits(2) == 0);
		end

		// enter and leave the bank with the first half held
		for (int n = 0; n < swapCycles; n++)
		begin
			@(posedge clock);
			if (n[0])
				bank = !bank;
			driveRandom(bank, n < swapCycles / 2);
		end

		repeat (2) @(posedge clock);
		$display("Everything OK");
		$finish;
	end

	initial
	begin
		#(watchdogCycles * clockPeriod);
		$display("watchdog expired before the test sequence finished");
		$display("Something failed");
		$fatal(1, "timeout");
	end

endmodule

/* sim.f */
design/regNumPkg.sv
design/regDataPkg.sv
design/gprFile.sv
design/operandRead.sv
design/controlRegs.sv
design/regBank.sv
dv/regBankTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= regBankTb
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= Everything OK
VFLAGS ?= --binary --timing --assert -Wno-fatal

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
